// File: soc_pkg.sv
package soc_pkg;

    // Bus geometry
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int SEL_W  = 4;
    localparam int PAGE_W = 8;

    // Address pages, compared against adr[31:24]
    localparam logic [PAGE_W-1:0] GPIO_PAGE  = 8'h40;
    localparam logic [PAGE_W-1:0] IRQ_PAGE   = 8'h80;
    localparam logic [PAGE_W-1:0] TIMER_PAGE = 8'hc0;

    // Peripheral sizes
    localparam int GPIO_W  = 8;
    localparam int IRQ_N   = 2;
    localparam int TIMER_W = 64;

    // Interrupt source bits
    localparam int IRQ_TIMER = 0;
    localparam int IRQ_GPIO  = 1;

    // Word offsets come from adr[3:2]
    localparam int OFS_LSB = 2;
    localparam int OFS_W   = 2;

    localparam logic [OFS_W-1:0] MTIME_LO    = 2'd0;
    localparam logic [OFS_W-1:0] MTIME_HI    = 2'd1;
    localparam logic [OFS_W-1:0] MTIMECMP_LO = 2'd2;
    localparam logic [OFS_W-1:0] MTIMECMP_HI = 2'd3;

    localparam logic [OFS_W-1:0] GPIO_OUT  = 2'd0;
    localparam logic [OFS_W-1:0] GPIO_IN   = 2'd1;
    localparam logic [OFS_W-1:0] GPIO_PEND = 2'd2;

    localparam logic [OFS_W-1:0] IRQ_EN     = 2'd0;
    localparam logic [OFS_W-1:0] IRQ_STATUS = 2'd1;

    // Compare starts out of reach so the timer stays quiet
    localparam logic [TIMER_W-1:0] MTIMECMP_RST = {TIMER_W{1'b1}};

    // Replace the bytes of old_word picked by sel
    function automatic logic [DATA_W-1:0] merge_bytes(
        input logic [DATA_W-1:0] old_word,
        input logic [DATA_W-1:0] new_word,
        input logic [SEL_W-1:0]  sel
    );
        logic [DATA_W-1:0] merged;
        merged = old_word;
        for (int b = 0; b < SEL_W; b++) begin
            if (sel[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

endpackage

// File: dbus_if.sv
`timescale 1ns/1ns

interface dbus_if;

    import soc_pkg::*;

    // Request side of the data bus
    logic [ADDR_W-1:0] adr;
    logic [DATA_W-1:0] dat;
    logic [SEL_W-1:0]  sel;
    logic              we;
    logic              cyc;

    // Driven by the bus owner
    modport master (
        output adr,
        output dat,
        output sel,
        output we,
        output cyc
    );

    // Each peripheral decodes its own page
    modport slave (
        input adr,
        input dat,
        input sel,
        input we,
        input cyc
    );

endinterface

// File: mtimer.sv
`timescale 1ns/1ns

module mtimer (
    input  logic                       i_ck,
    input  logic                       i_reset_loop,
    dbus_if.slave                      bus,
    output logic [soc_pkg::DATA_W-1:0] o_rdt,
    output logic                       o_ack,
    output logic                       o_irq
);

    import soc_pkg::*;

    logic [TIMER_W-1:0] mtime;
    logic [TIMER_W-1:0] mtimecmp;
    logic               hit;
    logic               start;
    logic [OFS_W-1:0]   ofs;
    logic [DATA_W-1:0]  rd_word;
    logic [DATA_W-1:0]  cmp_lo_next;
    logic [DATA_W-1:0]  cmp_hi_next;

    // Page decode
    assign hit = bus.cyc && (bus.adr[ADDR_W-1 -: PAGE_W] == TIMER_PAGE);

    // No new access while the ack is out
    assign start = hit && !o_ack;

    assign ofs = bus.adr[OFS_LSB +: OFS_W];

    // Free-running counter
    always_ff @(posedge i_ck) begin
        if (i_reset_loop) begin
            mtime <= '0;
        end else begin
            mtime <= mtime + 1'b1;
        end
    end

    // Byte-merged candidates for the compare words
    assign cmp_lo_next = merge_bytes(mtimecmp[DATA_W-1:0], bus.dat, bus.sel);
    assign cmp_hi_next = merge_bytes(mtimecmp[TIMER_W-1:DATA_W], bus.dat, bus.sel);

    // Compare register, written one word at a time
    always_ff @(posedge i_ck) begin
        if (i_reset_loop) begin
            mtimecmp <= MTIMECMP_RST;
        end else if (start && bus.we) begin
            case (ofs)
                MTIMECMP_LO: begin
                    mtimecmp[DATA_W-1:0] <= cmp_lo_next;
                end
                MTIMECMP_HI: begin
                    mtimecmp[TIMER_W-1:DATA_W] <= cmp_hi_next;
                end
                default: begin
                    // mtime itself is read only
                end
            endcase
        end
    end

    // Read mux over the four words
    always_comb begin
        case (ofs)
            MTIME_LO:    rd_word = mtime[DATA_W-1:0];
            MTIME_HI:    rd_word = mtime[TIMER_W-1:DATA_W];
            MTIMECMP_LO: rd_word = mtimecmp[DATA_W-1:0];
            default:     rd_word = mtimecmp[TIMER_W-1:DATA_W];
        endcase
    end

    // One-cycle ack, read data only while acking
    always_ff @(posedge i_ck) begin
        if (i_reset_loop) begin
            o_ack <= 1'b0;
            o_rdt <= '0;
        end else begin
            o_ack <= start;
            if (start && !bus.we) begin
                o_rdt <= rd_word;
            end else begin
                o_rdt <= '0;
            end
        end
    end

    // Level interrupt over the full 64 bits
    // Software writes the high compare word first to avoid a false hit
    always_ff @(posedge i_ck) begin
        if (i_reset_loop) begin
            o_irq <= 1'b0;
        end else begin
            o_irq <= (mtime >= mtimecmp);
        end
    end

endmodule

// File: gpio_port.sv
`timescale 1ns/1ns

module gpio_port (
    input  logic                       i_ck,
    input  logic                       i_reset_loop,
    dbus_if.slave                      bus,
    input  logic [soc_pkg::GPIO_W-1:0] i_pins,
    output logic [soc_pkg::GPIO_W-1:0] o_pins,
    output logic [soc_pkg::DATA_W-1:0] o_rdt,
    output logic                       o_ack,
    output logic                       o_irq
);

    import soc_pkg::*;

    logic [GPIO_W-1:0] out_q;
    logic [GPIO_W-1:0] sync_q1;
    logic [GPIO_W-1:0] sync_q2;
    logic [GPIO_W-1:0] prev_q;
    logic [GPIO_W-1:0] pend;
    logic [GPIO_W-1:0] rise;
    logic [GPIO_W-1:0] clr;
    logic [DATA_W-1:0] out_next;
    logic [DATA_W-1:0] clr_word;
    logic [DATA_W-1:0] rd_word;
    logic [OFS_W-1:0]  ofs;
    logic              hit;
    logic              start;

    assign hit   = bus.cyc && (bus.adr[ADDR_W-1 -: PAGE_W] == GPIO_PAGE);
    assign start = hit && !o_ack;
    assign ofs   = bus.adr[OFS_LSB +: OFS_W];

    // Output register
    assign out_next = merge_bytes(DATA_W'(out_q), bus.dat, bus.sel);

    always_ff @(posedge i_ck) begin
        if (i_reset_loop) begin
            out_q <= '0;
        end else if (start && bus.we && (ofs == GPIO_OUT)) begin
            out_q <= out_next[GPIO_W-1:0];
        end
    end

    assign o_pins = out_q;

    // Two-flop synchroniser, then one more stage for edge detect
    always_ff @(posedge i_ck) begin
        if (i_reset_loop) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
            prev_q  <= '0;
        end else begin
            sync_q1 <= i_pins;
            sync_q2 <= sync_q1;
            prev_q  <= sync_q2;
        end
    end

    assign rise = sync_q2 & ~prev_q;

    // Write-one-to-clear, byte selects honoured
    assign clr_word = merge_bytes('0, bus.dat, bus.sel);
    assign clr = (start && bus.we && (ofs == GPIO_PEND)) ? clr_word[GPIO_W-1:0] : '0;

    // A new edge beats a clear in the same cycle
    always_ff @(posedge i_ck) begin
        if (i_reset_loop) begin
            pend <= '0;
        end else begin
            pend <= (pend & ~clr) | rise;
        end
    end

    assign o_irq = |pend;

    always_comb begin
        case (ofs)
            GPIO_OUT:  rd_word = DATA_W'(out_q);
            GPIO_IN:   rd_word = DATA_W'(sync_q2);
            GPIO_PEND: rd_word = DATA_W'(pend);
            default:   rd_word = '0;
        endcase
    end

    always_ff @(posedge i_ck) begin
        if (i_reset_loop) begin
            o_ack <= 1'b0;
            o_rdt <= '0;
        end else begin
            o_ack <= start;
            o_rdt <= (start && !bus.we) ? rd_word : '0;
        end
    end

endmodule

// File: irq_ctrl.sv
`timescale 1ns/1ns

module irq_ctrl (
    input  logic                       i_ck,
    input  logic                       i_reset_loop,
    dbus_if.slave                      bus,
    input  logic [soc_pkg::IRQ_N-1:0]  i_src,
    input  logic [soc_pkg::DATA_W-1:0] i_timer_rdt,
    input  logic                       i_timer_ack,
    input  logic [soc_pkg::DATA_W-1:0] i_gpio_rdt,
    input  logic                       i_gpio_ack,
    output logic [soc_pkg::DATA_W-1:0] o_rdt,
    output logic                       o_ack,
    output logic                       o_irq
);

    import soc_pkg::*;

    logic [IRQ_N-1:0]  en;
    logic [DATA_W-1:0] en_next;
    logic [DATA_W-1:0] rd_word;
    logic [DATA_W-1:0] own_rdt;
    logic              own_ack;
    logic [OFS_W-1:0]  ofs;
    logic              hit;
    logic              start;

    assign hit   = bus.cyc && (bus.adr[ADDR_W-1 -: PAGE_W] == IRQ_PAGE);
    assign start = hit && !own_ack;
    assign ofs   = bus.adr[OFS_LSB +: OFS_W];

    // Enable mask, only the low IRQ_N bits exist
    assign en_next = merge_bytes(DATA_W'(en), bus.dat, bus.sel);

    always_ff @(posedge i_ck) begin
        if (i_reset_loop) begin
            en <= '0;
        end else if (start && bus.we && (ofs == IRQ_EN)) begin
            en <= en_next[IRQ_N-1:0];
        end
    end

    // Status shows the sources before masking
    always_comb begin
        case (ofs)
            IRQ_EN:     rd_word = DATA_W'(en);
            IRQ_STATUS: rd_word = DATA_W'(i_src);
            default:    rd_word = '0;
        endcase
    end

    always_ff @(posedge i_ck) begin
        if (i_reset_loop) begin
            own_ack <= 1'b0;
            own_rdt <= '0;
        end else begin
            own_ack <= start;
            own_rdt <= (start && !bus.we) ? rd_word : '0;
        end
    end

    // CPU interrupt line
    always_ff @(posedge i_ck) begin
        if (i_reset_loop) begin
            o_irq <= 1'b0;
        end else begin
            o_irq <= |(i_src & en);
        end
    end

    // Every slave holds zero when idle, so a plain OR merges them
    assign o_rdt = own_rdt | i_timer_rdt | i_gpio_rdt;
    assign o_ack = own_ack | i_timer_ack | i_gpio_ack;

endmodule

// File: dbus_periph.sv
`timescale 1ns/1ns

module dbus_periph (
    input  logic                       i_ck,
    input  logic                       i_reset_loop,
    input  logic [soc_pkg::ADDR_W-1:0] i_adr,
    input  logic [soc_pkg::DATA_W-1:0] i_dat,
    input  logic [soc_pkg::SEL_W-1:0]  i_sel,
    input  logic                       i_we,
    input  logic                       i_cyc,
    output logic [soc_pkg::DATA_W-1:0] o_rdt,
    output logic                       o_ack,
    input  logic [soc_pkg::GPIO_W-1:0] i_gpio,
    output logic [soc_pkg::GPIO_W-1:0] o_gpio,
    output logic                       o_irq
);

    import soc_pkg::*;

    logic [DATA_W-1:0] timer_rdt;
    logic              timer_ack;
    logic              timer_irq;
    logic [DATA_W-1:0] gpio_rdt;
    logic              gpio_ack;
    logic              gpio_irq;
    logic [IRQ_N-1:0]  irq_src;

    // Master request from the CPU side
    dbus_if dbus ();

    assign dbus.adr = i_adr;
    assign dbus.dat = i_dat;
    assign dbus.sel = i_sel;
    assign dbus.we  = i_we;
    assign dbus.cyc = i_cyc;

    mtimer mtimer_i (
        .i_ck         (i_ck),
        .i_reset_loop (i_reset_loop),
        .bus          (dbus.slave),
        .o_rdt        (timer_rdt),
        .o_ack        (timer_ack),
        .o_irq        (timer_irq)
    );

    gpio_port gpio_port_i (
        .i_ck         (i_ck),
        .i_reset_loop (i_reset_loop),
        .bus          (dbus.slave),
        .i_pins       (i_gpio),
        .o_pins       (o_gpio),
        .o_rdt        (gpio_rdt),
        .o_ack        (gpio_ack),
        .o_irq        (gpio_irq)
    );

    // Bit 0 timer, bit 1 GPIO
    assign irq_src[IRQ_TIMER] = timer_irq;
    assign irq_src[IRQ_GPIO]  = gpio_irq;

    // Also merges the responses onto the bus
    irq_ctrl irq_ctrl_i (
        .i_ck         (i_ck),
        .i_reset_loop (i_reset_loop),
        .bus          (dbus.slave),
        .i_src        (irq_src),
        .i_timer_rdt  (timer_rdt),
        .i_timer_ack  (timer_ack),
        .i_gpio_rdt   (gpio_rdt),
        .i_gpio_ack   (gpio_ack),
        .o_rdt        (o_rdt),
        .o_ack        (o_ack),
        .o_irq        (o_irq)
    );

endmodule

// File: tb_dbus_periph.sv
`timescale 1ns/1ns

module tb_dbus_periph;

    import soc_pkg::*;

    localparam int MAX_ROWS  = 96;
    localparam int ACK_LIMIT = 8;

    // Row operations
    localparam int OP_RD    = 0;
    localparam int OP_WR    = 1;
    localparam int OP_IRQ   = 2;
    localparam int OP_LVL   = 3;
    localparam int OP_OUT   = 4;
    localparam int OP_RDGT  = 5;
    localparam int OP_WREL  = 6;
    localparam int OP_NOACK = 7;
    localparam int OP_IDLE  = 8;

    logic              ck;
    logic              i_reset_loop;
    logic [ADDR_W-1:0] i_adr;
    logic [DATA_W-1:0] i_dat;
    logic [SEL_W-1:0]  i_sel;
    logic              i_we;
    logic              i_cyc;
    logic [DATA_W-1:0] o_rdt;
    logic              o_ack;
    logic [GPIO_W-1:0] i_gpio;
    logic [GPIO_W-1:0] o_gpio;
    logic              o_irq;

    // Stimulus table with one entry per row in each column
    int          row_op   [MAX_ROWS];
    logic [31:0] row_adr  [MAX_ROWS];
    logic [31:0] row_dat  [MAX_ROWS];
    logic [3:0]  row_sel  [MAX_ROWS];
    logic [7:0]  row_pins [MAX_ROWS];
    logic [31:0] row_exp  [MAX_ROWS];
    logic [31:0] row_mask [MAX_ROWS];
    int          n_rows = 0;
    logic        table_ready = 1'b0;

    int          errors;
    int          cycle_cnt;
    logic [31:0] rng;
    logic [7:0]  cur_pins;
    logic [31:0] last_rd;

    dbus_periph dbus_periph_i (
        .i_ck         (ck),
        .i_reset_loop (i_reset_loop),
        .i_adr        (i_adr),
        .i_dat        (i_dat),
        .i_sel        (i_sel),
        .i_we         (i_we),
        .i_cyc        (i_cyc),
        .o_rdt        (o_rdt),
        .o_ack        (o_ack),
        .i_gpio       (i_gpio),
        .o_gpio       (o_gpio),
        .o_irq        (o_irq)
    );

    initial ck = 1'b0;
    always #2 ck = ~ck;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Expected register contents after a write with byte selects
    function automatic logic [31:0] apply_byte_sel(input logic [31:0] old_word,
                                                   input logic [31:0] new_word,
                                                   input logic [3:0]  sel);
        logic [31:0] m;
        m = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
        return (old_word & ~m) | (new_word & m);
    endfunction

    function automatic logic [31:0] reg_adr(input logic [7:0] page, input logic [1:0] ofs);
        return {page, 20'h0, ofs, 2'b00};
    endfunction

    task automatic add_row(input int op, input logic [31:0] adr, input logic [31:0] dat,
                           input logic [3:0] sel, input logic [31:0] expected,
                           input logic [31:0] mask);
        row_op[n_rows]   = op;
        row_adr[n_rows]  = adr;
        row_dat[n_rows]  = dat;
        row_sel[n_rows]  = sel;
        row_pins[n_rows] = cur_pins;
        row_exp[n_rows]  = expected;
        row_mask[n_rows] = mask;
        n_rows++;
    endtask

    task automatic add_read(input logic [31:0] adr, input logic [31:0] expected,
                            input logic [31:0] mask);
        add_row(OP_RD, adr, '0, 4'hf, expected, mask);
    endtask

    task automatic add_write(input logic [31:0] adr, input logic [31:0] dat,
                             input logic [3:0] sel);
        add_row(OP_WR, adr, dat, sel, '0, '0);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected, input logic [31:0] mask);
        if ((got & mask) !== (expected & mask)) begin
            errors++;
            $display("ERROR %s: got %h, expected %h, mask %h", name, got, expected, mask);
        end
    endtask

    // One bus cycle that holds cyc until the ack or the give-up limit
    task automatic bus_access(input logic [31:0] adr, input logic [31:0] dat,
                              input logic [3:0] sel, input logic we, input logic expect_ack,
                              output logic [31:0] rdt);
        int   lat;
        logic acked;
        lat   = 0;
        acked = 1'b0;
        rdt   = '0;
        @(posedge ck);
        i_adr <= adr;
        i_dat <= dat;
        i_sel <= sel;
        i_we  <= we;
        i_cyc <= 1'b1;
        while (!acked && lat < ACK_LIMIT) begin
            @(posedge ck);
            lat++;
            @(negedge ck);
            if (o_ack) begin
                acked = 1'b1;
                rdt   = o_rdt;
            end else begin
                check_value("o_rdt", o_rdt, '0, '1);
            end
        end
        @(posedge ck);
        i_cyc <= 1'b0;
        i_we  <= 1'b0;
        if (acked && expect_ack) begin
            check_value("ack_latency", lat, 1, '1);
        end else if (acked) begin
            errors++;
            $display("Address %h is unmapped but was acknowledged", adr);
        end else if (expect_ack) begin
            errors++;
            $display("No acknowledge from address %h within %0d cycles", adr, ACK_LIMIT);
        end
    endtask

    task automatic wait_irq(input logic level, input int limit);
        int n;
        n = 0;
        @(negedge ck);
        while (o_irq !== level && n < limit) begin
            @(negedge ck);
            n++;
        end
        if (o_irq !== level) begin
            errors++;
            $display("o_irq did not go to %0d within %0d cycles", level, limit);
        end
    endtask

    task automatic run_row(input int i);
        logic [31:0] rdt;
        @(posedge ck);
        i_gpio <= row_pins[i];
        case (row_op[i])
            OP_RD, OP_RDGT: begin
                bus_access(row_adr[i], '0, 4'hf, 1'b0, 1'b1, rdt);
                if (row_op[i] == OP_RDGT) begin
                    check_value("mtime_lo_increase", rdt > last_rd, 1, 1);
                end else if (row_mask[i] != '0) begin
                    check_value("o_rdt", rdt, row_exp[i], row_mask[i]);
                end
                // An empty mask only samples the value for a later row
                last_rd = rdt;
            end
            OP_WR: bus_access(row_adr[i], row_dat[i], row_sel[i], 1'b1, 1'b1, rdt);
            // Data relative to the last value read
            OP_WREL: bus_access(row_adr[i], last_rd + row_dat[i], row_sel[i], 1'b1, 1'b1, rdt);
            OP_NOACK: bus_access(row_adr[i], '0, 4'hf, 1'b0, 1'b0, rdt);
            OP_IRQ: wait_irq(row_exp[i][0], row_dat[i]);
            OP_LVL: begin
                repeat (row_dat[i]) @(negedge ck);
                check_value("o_irq", o_irq, row_exp[i], 1);
            end
            OP_OUT: begin
                @(negedge ck);
                check_value("o_gpio", o_gpio, row_exp[i], row_mask[i]);
            end
            default: repeat (row_dat[i]) @(posedge ck);
        endcase
    endtask

    task automatic build_table();
        logic [31:0] m_out;
        logic [31:0] m_en;
        logic [31:0] m_cmp_lo;
        logic [31:0] m_cmp_hi;
        logic [3:0]  sel_list [4];
        int          k;
        sel_list[0] = 4'hf;
        sel_list[1] = 4'h1;
        sel_list[2] = 4'h6;
        sel_list[3] = 4'h9;
        m_out    = '0;
        m_en     = '0;
        m_cmp_lo = '1;
        m_cmp_hi = '1;
        cur_pins = '0;

        // Values after reset while mtime is still small
        add_read(reg_adr(GPIO_PAGE, GPIO_OUT), '0, '1);
        add_read(reg_adr(GPIO_PAGE, GPIO_PEND), '0, '1);
        add_read(reg_adr(IRQ_PAGE, IRQ_EN), '0, '1);
        add_read(reg_adr(TIMER_PAGE, MTIMECMP_LO), '1, '1);
        add_read(reg_adr(TIMER_PAGE, MTIMECMP_HI), '1, '1);
        add_read(reg_adr(TIMER_PAGE, MTIME_HI), '0, '1);
        add_read(reg_adr(TIMER_PAGE, MTIME_LO), '0, 32'hffff_ff00);
        add_row(OP_LVL, '0, 1, '0, '0, 1);
        add_row(OP_OUT, '0, '0, '0, '0, 32'hff);

        // Random write and read-back with full and partial byte selects
        for (k = 0; k < 4; k++) begin
            rng = xorshift(rng);
            m_out = apply_byte_sel(m_out, rng, sel_list[k]) & 32'hff;
            add_write(reg_adr(GPIO_PAGE, GPIO_OUT), rng, sel_list[k]);
            add_read(reg_adr(GPIO_PAGE, GPIO_OUT), m_out, '1);
            add_row(OP_OUT, '0, '0, '0, m_out, 32'hff);
            rng = xorshift(rng);
            m_en = apply_byte_sel(m_en, rng, sel_list[k]) & ((1 << IRQ_N) - 1);
            add_write(reg_adr(IRQ_PAGE, IRQ_EN), rng, sel_list[k]);
            add_read(reg_adr(IRQ_PAGE, IRQ_EN), m_en, '1);
            rng = xorshift(rng);
            m_cmp_lo = apply_byte_sel(m_cmp_lo, rng, sel_list[k]);
            add_write(reg_adr(TIMER_PAGE, MTIMECMP_LO), rng, sel_list[k]);
            add_read(reg_adr(TIMER_PAGE, MTIMECMP_LO), m_cmp_lo, '1);
            rng = xorshift(rng);
            m_cmp_hi = apply_byte_sel(m_cmp_hi, rng, sel_list[k]);
            add_write(reg_adr(TIMER_PAGE, MTIMECMP_HI), rng, sel_list[k]);
            add_read(reg_adr(TIMER_PAGE, MTIMECMP_HI), m_cmp_hi, '1);
        end
        add_write(reg_adr(IRQ_PAGE, IRQ_EN), '0, 4'hf);
        add_write(reg_adr(TIMER_PAGE, MTIMECMP_HI), '1, 4'hf);
        add_write(reg_adr(TIMER_PAGE, MTIMECMP_LO), '1, 4'hf);
        add_row(OP_LVL, '0, 3, '0, '0, 1);

        // Timer fires about 50 ticks after the compare write
        add_write(reg_adr(IRQ_PAGE, IRQ_EN), 1 << IRQ_TIMER, 4'hf);
        add_read(reg_adr(TIMER_PAGE, MTIME_LO), '0, '0);
        add_row(OP_RDGT, reg_adr(TIMER_PAGE, MTIME_LO), '0, 4'hf, '0, '0);
        add_write(reg_adr(TIMER_PAGE, MTIMECMP_HI), '0, 4'hf);
        add_row(OP_WREL, reg_adr(TIMER_PAGE, MTIMECMP_LO), 50, 4'hf, '0, '0);
        add_row(OP_IRQ, '0, 100, '0, 1, 1);
        add_read(reg_adr(IRQ_PAGE, IRQ_STATUS), 1 << IRQ_TIMER, 1 << IRQ_TIMER);
        add_write(reg_adr(TIMER_PAGE, MTIMECMP_HI), '1, 4'hf);
        add_write(reg_adr(TIMER_PAGE, MTIMECMP_LO), '1, 4'hf);
        add_row(OP_IRQ, '0, 10, '0, 0, 1);
        add_write(reg_adr(IRQ_PAGE, IRQ_EN), '0, 4'hf);

        // GPIO rising edges and then falling edges that set nothing
        cur_pins = 8'h5a;
        add_row(OP_IDLE, '0, 5, '0, '0, '0);
        add_read(reg_adr(GPIO_PAGE, GPIO_PEND), 32'h5a, '1);
        add_read(reg_adr(GPIO_PAGE, GPIO_IN), 32'h5a, '1);
        cur_pins = 8'h18;
        add_row(OP_IDLE, '0, 5, '0, '0, '0);
        add_read(reg_adr(GPIO_PAGE, GPIO_PEND), 32'h5a, '1);
        add_read(reg_adr(GPIO_PAGE, GPIO_IN), 32'h18, '1);
        add_write(reg_adr(GPIO_PAGE, GPIO_PEND), 32'h12, 4'hf);
        add_read(reg_adr(GPIO_PAGE, GPIO_PEND), 32'h48, '1);
        // Byte 0 not selected so nothing clears
        add_write(reg_adr(GPIO_PAGE, GPIO_PEND), 32'hff, 4'h2);
        add_read(reg_adr(GPIO_PAGE, GPIO_PEND), 32'h48, '1);

        // Pending GPIO bit gated by IRQ_EN
        add_row(OP_LVL, '0, 3, '0, '0, 1);
        add_read(reg_adr(IRQ_PAGE, IRQ_STATUS), 1 << IRQ_GPIO, 1 << IRQ_GPIO);
        add_write(reg_adr(IRQ_PAGE, IRQ_EN), 1 << IRQ_GPIO, 4'hf);
        add_row(OP_IRQ, '0, 10, '0, 1, 1);
        add_write(reg_adr(GPIO_PAGE, GPIO_PEND), 32'hff, 4'hf);
        add_row(OP_IRQ, '0, 10, '0, 0, 1);
        add_read(reg_adr(GPIO_PAGE, GPIO_PEND), '0, '1);
        add_write(reg_adr(IRQ_PAGE, IRQ_EN), '0, 4'hf);
        add_row(OP_OUT, '0, '0, '0, m_out, 32'hff);

        // Page 0x10 belongs to nobody
        add_row(OP_NOACK, 32'h1000_0000, '0, 4'hf, '0, '0);
    endtask

    initial begin
        int cycle_limit;
        wait (table_ready);
        cycle_limit = n_rows * 40 + 200;
        cycle_cnt = 0;
        while (cycle_cnt < cycle_limit) begin
            @(posedge ck);
            cycle_cnt++;
        end
        $display("Timeout: run stopped after %0d cycles", cycle_cnt);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        int i;
        errors       = 0;
        rng          = 32'd53;
        last_rd      = '0;
        i_reset_loop = 1'b1;
        i_adr        = '0;
        i_dat        = '0;
        i_sel        = '0;
        i_we         = 1'b0;
        i_cyc        = 1'b0;
        i_gpio       = '0;
        build_table();
        table_ready = 1'b1;
        repeat (5) @(posedge ck);
        i_reset_loop <= 1'b0;
        for (i = 0; i < n_rows; i++) begin
            run_row(i);
        end
        repeat (2) @(posedge ck);
        $display("Summary: %0d rows, %0d errors", n_rows, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: flist.f
soc_pkg.sv
dbus_if.sv
mtimer.sv
gpio_port.sv
irq_ctrl.sv
dbus_periph.sv
tb_dbus_periph.sv

// File: Bender.yml
package:
  name: dbus_periph

sources:
  - soc_pkg.sv
  - dbus_if.sv
  - mtimer.sv
  - gpio_port.sv
  - irq_ctrl.sv
  - dbus_periph.sv
  - target: simulation
    files:
      - tb_dbus_periph.sv
